// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - logic/rv_isa_pkg.sv
  - logic/decode_pkg.sv
  - logic/inst_decoder.sv
  - logic/fetch_receiver.sv
  - logic/decode_queue.sv
  - logic/decode_stage.sv
  - target: test
    files:
      - dv/decode_stage_tb.sv

// ==== dv/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb;

	localparam logic [31:0] SEED = 32'h6d96f8ec;
	localparam int WAIT_LIMIT = 200;
	localparam int RANDOM_ITEMS = 200;
	localparam int STALL_CYCLES = 20;

	// one dispatch record in the order of the disp_* ports
	typedef struct packed {
		decode_pkg::fu_t fu;
		decode_pkg::op_t op;
		rv_isa_pkg::reg_idx_t src1;
		rv_isa_pkg::reg_idx_t src2;
		rv_isa_pkg::reg_idx_t dest;
		logic rs1_v;
		logic rs2_v;
		rv_isa_pkg::word_t imm;
		logic imm_v;
		logic pc_v;
		rv_isa_pkg::word_t pc;
		logic [2:0] func3;
		logic csr;
		logic halt;
		logic illegal;
	} rec_t;

	logic clk;
	logic reset;
	logic flush;
	logic fetch_req;
	rv_isa_pkg::inst_t fetch_inst;
	rv_isa_pkg::word_t fetch_pc;
	logic disp_ack;
	logic fetch_ack;
	logic disp_req;
	decode_pkg::fu_t disp_fu;
	decode_pkg::op_t disp_op;
	rv_isa_pkg::reg_idx_t disp_src1;
	rv_isa_pkg::reg_idx_t disp_src2;
	rv_isa_pkg::reg_idx_t disp_dest;
	logic disp_rs1_valid;
	logic disp_rs2_valid;
	rv_isa_pkg::word_t disp_imm;
	logic disp_imm_valid;
	logic disp_pc_valid;
	rv_isa_pkg::word_t disp_pc;
	logic [2:0] disp_func3;
	logic disp_csr_op;
	logic disp_halt;
	logic disp_illegal;

	rec_t got;
	rec_t exp_q[$];
	logic [31:0] pc_next;
	int n_pass = 0;
	int n_fail = 0;
	int pass_mark;
	int fail_mark;
	int n_csr;
	int n_halt;
	int n_illegal;
	logic prev_fetch_req = 1'b0;
	logic prev_fetch_ack = 1'b0;
	logic prev_disp_req = 1'b0;
	logic prev_disp_ack = 1'b0;

	decode_stage decode_stage_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.fetch_req(fetch_req),
		.fetch_inst(fetch_inst),
		.fetch_pc(fetch_pc),
		.disp_ack(disp_ack),
		.fetch_ack(fetch_ack),
		.disp_req(disp_req),
		.disp_fu(disp_fu),
		.disp_op(disp_op),
		.disp_src1(disp_src1),
		.disp_src2(disp_src2),
		.disp_dest(disp_dest),
		.disp_rs1_valid(disp_rs1_valid),
		.disp_rs2_valid(disp_rs2_valid),
		.disp_imm(disp_imm),
		.disp_imm_valid(disp_imm_valid),
		.disp_pc_valid(disp_pc_valid),
		.disp_pc(disp_pc),
		.disp_func3(disp_func3),
		.disp_csr_op(disp_csr_op),
		.disp_halt(disp_halt),
		.disp_illegal(disp_illegal)
	);

	assign got = {disp_fu, disp_op, disp_src1, disp_src2, disp_dest, disp_rs1_valid,
		disp_rs2_valid, disp_imm, disp_imm_valid, disp_pc_valid, disp_pc, disp_func3,
		disp_csr_op, disp_halt, disp_illegal};

	always #4 clk = ~clk;

	function automatic decode_pkg::op_t alu_code(input logic [2:0] f3, input logic alt);
		decode_pkg::op_t code;
		case (f3)
			3'd0: code = alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
			3'd1: code = decode_pkg::ALU_SLL;
			3'd2: code = decode_pkg::ALU_SLT;
			3'd3: code = decode_pkg::ALU_SLTU;
			3'd4: code = decode_pkg::ALU_XOR;
			3'd5: code = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
			3'd6: code = decode_pkg::ALU_OR;
			default: code = decode_pkg::ALU_AND;
		endcase
		return code;
	endfunction

	// reference decode taken straight from the RV32IM encoding tables
	function automatic rec_t predict(input logic [31:0] w, input logic [31:0] pc);
		rec_t r;
		logic bad;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] imm_i;
		r = '0;
		bad = 1'b0;
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		case (w[6:0])
			7'b0110111, 7'b0010111: begin
				// lui and auipc differ only in bit 5
				r.dest = w[11:7];
				r.imm = {w[31:12], 12'h000};
				r.imm_v = 1'b1;
				r.pc_v = ~w[5];
			end
			7'b1101111: begin
				r.fu = decode_pkg::FU_BTU;
				r.op = decode_pkg::BTU_JAL;
				r.dest = w[11:7];
				r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				r.imm_v = 1'b1;
				r.pc_v = 1'b1;
			end
			7'b1100111: begin
				bad = (f3 != 3'd0);
				r.fu = decode_pkg::FU_BTU;
				r.op = decode_pkg::BTU_JALR;
				r.src1 = w[19:15];
				r.rs1_v = 1'b1;
				r.dest = w[11:7];
				r.imm = imm_i;
				r.imm_v = 1'b1;
				r.pc_v = 1'b1;
			end
			7'b1100011: begin
				bad = (f3 == 3'd2 || f3 == 3'd3);
				r.fu = decode_pkg::FU_BTU;
				case (f3)
					3'd0: r.op = decode_pkg::BTU_BEQ;
					3'd1: r.op = decode_pkg::BTU_BNE;
					3'd4: r.op = decode_pkg::BTU_BLT;
					3'd5: r.op = decode_pkg::BTU_BGE;
					3'd6: r.op = decode_pkg::BTU_BLTU;
					default: r.op = decode_pkg::BTU_BGEU;
				endcase
				r.src1 = w[19:15];
				r.src2 = w[24:20];
				r.rs1_v = 1'b1;
				r.rs2_v = 1'b1;
				r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				r.imm_v = 1'b1;
				r.pc_v = 1'b1;
			end
			7'b0000011: begin
				bad = (f3 == 3'd3 || f3 > 3'd5);
				r.fu = decode_pkg::FU_LSU;
				r.op = f3[2] ? decode_pkg::LS_LOADU : decode_pkg::LS_LOAD;
				r.src1 = w[19:15];
				r.rs1_v = 1'b1;
				r.dest = w[11:7];
				r.imm = imm_i;
				r.imm_v = 1'b1;
				r.func3 = f3;
			end
			7'b0100011: begin
				bad = (f3 > 3'd2);
				r.fu = decode_pkg::FU_LSU;
				r.op = decode_pkg::LS_STORE;
				r.src1 = w[19:15];
				r.src2 = w[24:20];
				r.rs1_v = 1'b1;
				r.rs2_v = 1'b1;
				r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
				r.imm_v = 1'b1;
				r.func3 = f3;
			end
			7'b0010011: begin
				bad = (f3 == 3'd1 && f7 != 7'h00) ||
					(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
				r.op = alu_code(f3, f3 == 3'd5 && f7 == 7'h20);
				r.src1 = w[19:15];
				r.rs1_v = 1'b1;
				r.dest = w[11:7];
				r.imm = imm_i;
				r.imm_v = 1'b1;
			end
			7'b0110011: begin
				r.src1 = w[19:15];
				r.src2 = w[24:20];
				r.dest = w[11:7];
				r.rs1_v = 1'b1;
				r.rs2_v = 1'b1;
				if (f7 == 7'h01) begin
					// divides have no unit
					bad = f3[2];
					r.fu = decode_pkg::FU_MULT;
					case (f3[1:0])
						2'd0: r.op = decode_pkg::MULT_MUL;
						2'd1: r.op = decode_pkg::MULT_MULH;
						2'd2: r.op = decode_pkg::MULT_MULHSU;
						default: r.op = decode_pkg::MULT_MULHU;
					endcase
				end else if (f7 == 7'h00) begin
					r.op = alu_code(f3, 1'b0);
				end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
					r.op = alu_code(f3, 1'b1);
				end else begin
					bad = 1'b1;
				end
			end
			7'b1110011: begin
				if (w == 32'h10500073) r.halt = 1'b1;
				else if (f3 >= 3'd1 && f3 <= 3'd3) r.csr = 1'b1;
				else bad = 1'b1;
			end
			default: bad = 1'b1;
		endcase
		if (bad) begin
			r = '0;
			r.illegal = 1'b1;
		end
		r.pc = pc;
		return r;
	endfunction

	// random word of a random class with registers and immediates left random
	function automatic logic [31:0] gen_inst();
		logic [31:0] w;
		int kind;
		int pick;
		logic alt;
		w = $urandom;
		kind = $urandom_range(0, 13);
		pick = $urandom_range(0, 5);
		alt = $urandom_range(0, 1);
		case (kind)
			0: w[6:0] = 7'b0110111;
			1: w[6:0] = 7'b0010111;
			2: w[6:0] = 7'b1101111;
			3: begin
				w[6:0] = 7'b1100111;
				w[14:12] = 3'd0;
			end
			4: begin
				w[6:0] = 7'b1100011;
				w[14:12] = (pick < 2) ? pick[2:0] : pick[2:0] + 3'd2;
			end
			5: begin
				w[6:0] = 7'b0000011;
				pick = pick % 5;
				w[14:12] = (pick < 3) ? pick[2:0] : pick[2:0] + 3'd1;
			end
			6: begin
				w[6:0] = 7'b0100011;
				w[14:12] = pick[2:0] % 3'd3;
			end
			7: begin
				w[6:0] = 7'b0010011;
				if (w[14:12] == 3'd1) w[31:25] = 7'h00;
				if (w[14:12] == 3'd5) w[31:25] = alt ? 7'h20 : 7'h00;
			end
			8: begin
				w[6:0] = 7'b0110011;
				w[31:25] = (alt && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ? 7'h20 : 7'h00;
			end
			9: begin
				w[6:0] = 7'b0110011;
				w[31:25] = 7'h01;
				w[14] = 1'b0;
			end
			10: begin
				w[6:0] = 7'b1110011;
				w[14:12] = 3'd1 + pick[2:0] % 3'd3;
			end
			11: w = 32'h10500073;
			// the remaining kinds keep the fully random word
			default: ;
		endcase
		return w;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic begin_send(input logic [31:0] w);
		fetch_inst = w;
		fetch_pc = pc_next;
		fetch_req = 1'b1;
		exp_q.push_back(predict(w, pc_next));
		pc_next = pc_next + 32'd4;
	endtask

	task automatic finish_send();
		int n;
		n = 0;
		while (!fetch_ack) begin
			if (n == WAIT_LIMIT) abort_run("fetch_ack never rose for a pending fetch_req");
			next_cycle();
			n++;
		end
		fetch_req = 1'b0;
		n = 0;
		while (fetch_ack) begin
			if (n == WAIT_LIMIT) abort_run("fetch_ack stayed high after fetch_req dropped");
			next_cycle();
			n++;
		end
	endtask

	task automatic fetch_items(input int count);
		for (int i = 0; i < count; i++) begin
			begin_send(gen_inst());
			finish_send();
			repeat ($urandom_range(0, 2)) next_cycle();
		end
	endtask

	task automatic wait_disp_req();
		int n;
		n = 0;
		while (!disp_req) begin
			if (n == WAIT_LIMIT) abort_run("disp_req never rose with records pending");
			next_cycle();
			n++;
		end
	endtask

	task automatic take_item();
		rec_t exp;
		int n;
		wait_disp_req();
		assert (exp_q.size() != 0) n_pass++;
		else begin
			$display("FAIL %0t: record with pc %h arrived with none expected", $time, got.pc);
			n_fail++;
		end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			assert (got === exp) n_pass++;
			else begin
				$display("FAIL %0t: record pc %h got %h expected %h", $time, exp.pc, got, exp);
				n_fail++;
			end
		end
		n_csr = n_csr + got.csr;
		n_halt = n_halt + got.halt;
		n_illegal = n_illegal + got.illegal;
		repeat ($urandom_range(0, 3)) next_cycle();
		disp_ack = 1'b1;
		n = 0;
		while (disp_req) begin
			if (n == WAIT_LIMIT) abort_run("disp_req stayed high after disp_ack rose");
			next_cycle();
			n++;
		end
		// ack may linger a few cycles after req falls
		repeat ($urandom_range(0, 3)) next_cycle();
		disp_ack = 1'b0;
	endtask

	task automatic start_test();
		pass_mark = n_pass;
		fail_mark = n_fail;
	endtask

	task automatic end_test(input string name);
		assert (exp_q.size() == 0) n_pass++;
		else begin
			$display("FAIL %0t: %0d expected records never arrived", $time, exp_q.size());
			n_fail++;
		end
		$display("test %s: %0d checks, %0d failed", name,
			n_pass - pass_mark + n_fail - fail_mark, n_fail - fail_mark);
	endtask

	// handshake rules judged on the values seen at the rising edge
	always @(negedge clk) begin
		if (fetch_ack && !prev_fetch_ack) begin
			assert (prev_fetch_req) n_pass++;
			else begin
				$display("FAIL %0t: fetch_ack rose while fetch_req was low", $time);
				n_fail++;
			end
		end
		if (disp_req && !prev_disp_req) begin
			assert (!prev_disp_ack) n_pass++;
			else begin
				$display("FAIL %0t: disp_req rose while disp_ack was high", $time);
				n_fail++;
			end
		end
		prev_fetch_req = fetch_req;
		prev_fetch_ack = fetch_ack;
		prev_disp_req = disp_req;
		prev_disp_ack = disp_ack;
	end

	initial begin
		logic quiet;
		rec_t head_rec;
		clk = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		fetch_req = 1'b0;
		fetch_inst = '0;
		fetch_pc = '0;
		disp_ack = 1'b0;
		pc_next = 32'h0000_1000;
		void'($urandom(SEED));
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test();
		assert (!fetch_ack && !disp_req) n_pass++;
		else begin
			$display("FAIL %0t: fetch_ack or disp_req high after reset", $time);
			n_fail++;
		end
		fork
			begin
				begin_send(gen_inst());
				next_cycle();
				assert (!fetch_ack) n_pass++;
				else begin
					$display("FAIL %0t: fetch_ack high on the first edge after req", $time);
					n_fail++;
				end
				next_cycle();
				assert (fetch_ack) n_pass++;
				else begin
					$display("FAIL %0t: fetch_ack low on the second edge after req", $time);
					n_fail++;
				end
				finish_send();
			end
			take_item();
		join
		end_test("reset_state");

		start_test();
		n_csr = 0;
		n_halt = 0;
		n_illegal = 0;
		fork
			fetch_items(RANDOM_ITEMS);
			repeat (RANDOM_ITEMS) take_item();
		join
		assert (n_csr > 0 && n_halt > 0 && n_illegal > 0) n_pass++;
		else begin
			$display("FAIL %0t: stream missed csr, wfi or illegal records", $time);
			n_fail++;
		end
		end_test("random_stream");

		// the queue fills while dispatch is stalled
		start_test();
		for (int i = 0; i < decode_pkg::QUEUE_DEPTH; i++) begin
			begin_send(gen_inst());
			finish_send();
		end
		begin_send(gen_inst());
		quiet = 1'b1;
		repeat (STALL_CYCLES) begin
			next_cycle();
			if (fetch_ack) quiet = 1'b0;
		end
		assert (quiet) n_pass++;
		else begin
			$display("FAIL %0t: fetch_ack rose while the queue was full", $time);
			n_fail++;
		end
		fork
			finish_send();
			take_item();
		join
		repeat (decode_pkg::QUEUE_DEPTH) take_item();
		end_test("back_pressure");

		start_test();
		for (int i = 0; i < decode_pkg::QUEUE_DEPTH; i++) begin
			begin_send(gen_inst());
			finish_send();
		end
		wait_disp_req();
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		// the presented head survives the flush
		head_rec = exp_q[0];
		exp_q.delete();
		exp_q.push_back(head_rec);
		fork
			fetch_items(3);
			repeat (4) take_item();
		join
		quiet = 1'b1;
		repeat (STALL_CYCLES) begin
			next_cycle();
			if (disp_req) quiet = 1'b0;
		end
		assert (quiet) n_pass++;
		else begin
			$display("FAIL %0t: a flushed record reached dispatch", $time);
			n_fail++;
		end
		end_test("flush");

		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/decode_pkg.sv ====
package decode_pkg;

	// functional unit of a decoded record
	typedef logic [1:0] fu_t;

	localparam fu_t FU_ALU = 2'd0;
	localparam fu_t FU_LSU = 2'd1;
	localparam fu_t FU_MULT = 2'd2;
	localparam fu_t FU_BTU = 2'd3;

	// operation within a unit, codes overlap between units
	typedef logic [3:0] op_t;

	localparam op_t ALU_ADD = 4'd0;
	localparam op_t ALU_SUB = 4'd1;
	localparam op_t ALU_SLT = 4'd2;
	localparam op_t ALU_SLTU = 4'd3;
	localparam op_t ALU_AND = 4'd4;
	localparam op_t ALU_OR = 4'd5;
	localparam op_t ALU_XOR = 4'd6;
	localparam op_t ALU_SLL = 4'd7;
	localparam op_t ALU_SRL = 4'd8;
	localparam op_t ALU_SRA = 4'd9;

	localparam op_t BTU_JAL = 4'd0;
	localparam op_t BTU_JALR = 4'd1;
	localparam op_t BTU_BEQ = 4'd2;
	localparam op_t BTU_BNE = 4'd3;
	localparam op_t BTU_BLT = 4'd4;
	localparam op_t BTU_BGE = 4'd5;
	localparam op_t BTU_BLTU = 4'd6;
	localparam op_t BTU_BGEU = 4'd7;

	localparam op_t LS_LOAD = 4'd0;
	localparam op_t LS_LOADU = 4'd1;
	localparam op_t LS_STORE = 4'd2;

	localparam op_t MULT_MUL = 4'd0;
	localparam op_t MULT_MULH = 4'd1;
	localparam op_t MULT_MULHSU = 4'd2;
	localparam op_t MULT_MULHU = 4'd3;

	// decode queue sizing
	localparam int QUEUE_DEPTH = 4;

	typedef logic [1:0] qptr_t;
	typedef logic [2:0] qcount_t;

endpackage

// ==== logic/decode_queue.sv ====
`timescale 1ns/100ps

module decode_queue (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic push,
	input decode_pkg::fu_t fu,
	input decode_pkg::op_t op,
	input rv_isa_pkg::reg_idx_t src1,
	input rv_isa_pkg::reg_idx_t src2,
	input rv_isa_pkg::reg_idx_t dest,
	input logic rs1_valid,
	input logic rs2_valid,
	input rv_isa_pkg::word_t imm,
	input logic imm_valid,
	input logic pc_valid,
	input logic [2:0] func3,
	input logic csr_op,
	input logic halt,
	input logic illegal,
	input rv_isa_pkg::word_t pc,
	input logic disp_ack,
	output logic queue_full,
	output logic disp_req,
	output decode_pkg::fu_t disp_fu,
	output decode_pkg::op_t disp_op,
	output rv_isa_pkg::reg_idx_t disp_src1,
	output rv_isa_pkg::reg_idx_t disp_src2,
	output rv_isa_pkg::reg_idx_t disp_dest,
	output logic disp_rs1_valid,
	output logic disp_rs2_valid,
	output rv_isa_pkg::word_t disp_imm,
	output logic disp_imm_valid,
	output logic disp_pc_valid,
	output rv_isa_pkg::word_t disp_pc,
	output logic [2:0] disp_func3,
	output logic disp_csr_op,
	output logic disp_halt,
	output logic disp_illegal
);

	// one record is every field flattened, seven of them single bits
	localparam int REC_W = $bits(decode_pkg::fu_t) + $bits(decode_pkg::op_t) +
		3 * $bits(rv_isa_pkg::reg_idx_t) + 2 * $bits(rv_isa_pkg::word_t) + 3 + 7;

	typedef enum logic [1:0] {
		tx_idle,
		tx_req,
		tx_wait_low
	} tx_state_t;

	tx_state_t tx_state;
	logic [REC_W-1:0] mem [decode_pkg::QUEUE_DEPTH];
	logic [REC_W-1:0] wr_rec;
	decode_pkg::qptr_t head;
	decode_pkg::qptr_t tail;
	decode_pkg::qcount_t count;
	logic presented;
	logic retire;

	assign wr_rec = {fu, op, src1, src2, dest, rs1_valid, rs2_valid, imm, imm_valid,
		pc_valid, pc, func3, csr_op, halt, illegal};
	assign {disp_fu, disp_op, disp_src1, disp_src2, disp_dest, disp_rs1_valid,
		disp_rs2_valid, disp_imm, disp_imm_valid, disp_pc_valid, disp_pc, disp_func3,
		disp_csr_op, disp_halt, disp_illegal} = mem[head];

	assign presented = (tx_state == tx_req);
	assign retire = presented && disp_ack;
	assign disp_req = presented;
	assign queue_full = (count == decode_pkg::qcount_t'(decode_pkg::QUEUE_DEPTH));

	always_ff @(posedge clk) begin
		if (push) mem[tail] <= wr_rec;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (flush) begin
			// keep only a head that dispatch already sees
			head <= head + decode_pkg::qptr_t'(retire);
			tail <= head + decode_pkg::qptr_t'(presented);
			count <= decode_pkg::qcount_t'(presented && !retire);
		end else begin
			if (push) tail <= tail + 1'b1;
			if (retire) head <= head + 1'b1;
			count <= count + decode_pkg::qcount_t'(push) - decode_pkg::qcount_t'(retire);
		end
	end

	// four-phase master toward dispatch
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_state <= tx_idle;
		end else begin
			case (tx_state)
				tx_idle: if (count != '0 && !flush) tx_state <= tx_req;
				tx_req: if (disp_ack) tx_state <= tx_wait_low;
				tx_wait_low: if (!disp_ack) tx_state <= tx_idle;
				default: tx_state <= tx_idle;
			endcase
		end
	end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic fetch_req,
	input rv_isa_pkg::inst_t fetch_inst,
	input rv_isa_pkg::word_t fetch_pc,
	input logic disp_ack,
	output logic fetch_ack,
	output logic disp_req,
	output decode_pkg::fu_t disp_fu,
	output decode_pkg::op_t disp_op,
	output rv_isa_pkg::reg_idx_t disp_src1,
	output rv_isa_pkg::reg_idx_t disp_src2,
	output rv_isa_pkg::reg_idx_t disp_dest,
	output logic disp_rs1_valid,
	output logic disp_rs2_valid,
	output rv_isa_pkg::word_t disp_imm,
	output logic disp_imm_valid,
	output logic disp_pc_valid,
	output rv_isa_pkg::word_t disp_pc,
	output logic [2:0] disp_func3,
	output logic disp_csr_op,
	output logic disp_halt,
	output logic disp_illegal
);

	rv_isa_pkg::inst_t cap_inst;
	rv_isa_pkg::word_t cap_pc;
	logic push;
	logic queue_full;

	// decoded fields, valid while push is high
	decode_pkg::fu_t dec_fu;
	decode_pkg::op_t dec_op;
	rv_isa_pkg::reg_idx_t dec_src1;
	rv_isa_pkg::reg_idx_t dec_src2;
	rv_isa_pkg::reg_idx_t dec_dest;
	logic dec_rs1_valid;
	logic dec_rs2_valid;
	rv_isa_pkg::word_t dec_imm;
	logic dec_imm_valid;
	logic dec_pc_valid;
	logic [2:0] dec_func3;
	logic dec_csr_op;
	logic dec_halt;
	logic dec_illegal;

	fetch_receiver fetch_receiver_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.fetch_req(fetch_req),
		.fetch_inst(fetch_inst),
		.fetch_pc(fetch_pc),
		.queue_full(queue_full),
		.fetch_ack(fetch_ack),
		.cap_inst(cap_inst),
		.cap_pc(cap_pc),
		.push(push)
	);

	inst_decoder inst_decoder_i (
		.in_valid(push),
		.inst(cap_inst),
		.fu(dec_fu),
		.op(dec_op),
		.src1(dec_src1),
		.src2(dec_src2),
		.dest(dec_dest),
		.rs1_valid(dec_rs1_valid),
		.rs2_valid(dec_rs2_valid),
		.imm(dec_imm),
		.imm_valid(dec_imm_valid),
		.pc_valid(dec_pc_valid),
		.func3(dec_func3),
		.csr_op(dec_csr_op),
		.halt(dec_halt),
		.illegal(dec_illegal)
	);

	decode_queue decode_queue_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.push(push),
		.fu(dec_fu),
		.op(dec_op),
		.src1(dec_src1),
		.src2(dec_src2),
		.dest(dec_dest),
		.rs1_valid(dec_rs1_valid),
		.rs2_valid(dec_rs2_valid),
		.imm(dec_imm),
		.imm_valid(dec_imm_valid),
		.pc_valid(dec_pc_valid),
		.func3(dec_func3),
		.csr_op(dec_csr_op),
		.halt(dec_halt),
		.illegal(dec_illegal),
		.pc(cap_pc),
		.disp_ack(disp_ack),
		.queue_full(queue_full),
		.disp_req(disp_req),
		.disp_fu(disp_fu),
		.disp_op(disp_op),
		.disp_src1(disp_src1),
		.disp_src2(disp_src2),
		.disp_dest(disp_dest),
		.disp_rs1_valid(disp_rs1_valid),
		.disp_rs2_valid(disp_rs2_valid),
		.disp_imm(disp_imm),
		.disp_imm_valid(disp_imm_valid),
		.disp_pc_valid(disp_pc_valid),
		.disp_pc(disp_pc),
		.disp_func3(disp_func3),
		.disp_csr_op(disp_csr_op),
		.disp_halt(disp_halt),
		.disp_illegal(disp_illegal)
	);

endmodule

// ==== logic/fetch_receiver.sv ====
`timescale 1ns/100ps

module fetch_receiver (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic fetch_req,
	input rv_isa_pkg::inst_t fetch_inst,
	input rv_isa_pkg::word_t fetch_pc,
	input logic queue_full,
	output logic fetch_ack,
	output rv_isa_pkg::inst_t cap_inst,
	output rv_isa_pkg::word_t cap_pc,
	output logic push
);

	typedef enum logic [1:0] {
		rx_idle,
		rx_write,
		rx_wait_drop
	} rx_state_t;

	rx_state_t state;
	logic take;

	// a new item is only taken when the queue has room
	assign take = (state == rx_idle) && fetch_req && !flush && !queue_full;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rx_idle;
		end else begin
			case (state)
				rx_idle: if (take) state <= rx_write;
				rx_write: state <= rx_wait_drop;
				rx_wait_drop: if (!fetch_req) state <= rx_idle;
				default: state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cap_inst <= fetch_inst;
			cap_pc <= fetch_pc;
		end
	end

	// flushed items are still acked, just never pushed
	assign push = (state == rx_write) && !flush;
	assign fetch_ack = (state == rx_wait_drop);

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
	input logic in_valid,
	input rv_isa_pkg::inst_t inst,
	output decode_pkg::fu_t fu,
	output decode_pkg::op_t op,
	output rv_isa_pkg::reg_idx_t src1,
	output rv_isa_pkg::reg_idx_t src2,
	output rv_isa_pkg::reg_idx_t dest,
	output logic rs1_valid,
	output logic rs2_valid,
	output rv_isa_pkg::word_t imm,
	output logic imm_valid,
	output logic pc_valid,
	output logic [2:0] func3,
	output logic csr_op,
	output logic halt,
	output logic illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_isa_pkg::reg_idx_t rd;
	rv_isa_pkg::reg_idx_t rs1;
	rv_isa_pkg::reg_idx_t rs2;
	rv_isa_pkg::word_t imm_i;
	rv_isa_pkg::word_t imm_s;
	rv_isa_pkg::word_t imm_b;
	rv_isa_pkg::word_t imm_u;
	rv_isa_pkg::word_t imm_j;

	assign opcode = inst[rv_isa_pkg::OPCODE_LSB +: 7];
	assign rd = inst[rv_isa_pkg::RD_LSB +: 5];
	assign funct3 = inst[rv_isa_pkg::FUNCT3_LSB +: 3];
	assign rs1 = inst[rv_isa_pkg::RS1_LSB +: 5];
	assign rs2 = inst[rv_isa_pkg::RS2_LSB +: 5];
	assign funct7 = inst[rv_isa_pkg::FUNCT7_LSB +: 7];

	// immediates per format, sign taken from bit 31
	assign imm_i = {{(rv_isa_pkg::XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_s = {{(rv_isa_pkg::XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{(rv_isa_pkg::XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{(rv_isa_pkg::XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// alu operation for a funct3, alt selects sub and sra
	function automatic decode_pkg::op_t alu_op(input logic [2:0] f3, input logic alt);
		case (f3)
			rv_isa_pkg::F3_ADD: return alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL: return decode_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT: return decode_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU: return decode_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR: return decode_pkg::ALU_XOR;
			rv_isa_pkg::F3_SR: return alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR: return decode_pkg::ALU_OR;
			default: return decode_pkg::ALU_AND;
		endcase
	endfunction

	always_comb begin
		// noop: an alu add with no operand in use
		fu = decode_pkg::FU_ALU;
		op = decode_pkg::ALU_ADD;
		src1 = '0;
		src2 = '0;
		dest = '0;
		rs1_valid = 1'b0;
		rs2_valid = 1'b0;
		imm = '0;
		imm_valid = 1'b0;
		pc_valid = 1'b0;
		func3 = 3'b000;
		csr_op = 1'b0;
		halt = 1'b0;
		illegal = 1'b0;

		if (in_valid) begin
			case (opcode)
				rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
					dest = rd;
					imm = imm_u;
					imm_valid = 1'b1;
					pc_valid = (opcode == rv_isa_pkg::OP_AUIPC);
				end
				rv_isa_pkg::OP_JAL: begin
					fu = decode_pkg::FU_BTU;
					op = decode_pkg::BTU_JAL;
					dest = rd;
					imm = imm_j;
					imm_valid = 1'b1;
					pc_valid = 1'b1;
				end
				rv_isa_pkg::OP_JALR: begin
					if (funct3 == rv_isa_pkg::F3_JALR) begin
						fu = decode_pkg::FU_BTU;
						op = decode_pkg::BTU_JALR;
						src1 = rs1;
						rs1_valid = 1'b1;
						dest = rd;
						imm = imm_i;
						imm_valid = 1'b1;
						pc_valid = 1'b1;
					end else begin
						illegal = 1'b1;
					end
				end
				rv_isa_pkg::OP_BRANCH: begin
					case (funct3)
						rv_isa_pkg::F3_BEQ: op = decode_pkg::BTU_BEQ;
						rv_isa_pkg::F3_BNE: op = decode_pkg::BTU_BNE;
						rv_isa_pkg::F3_BLT: op = decode_pkg::BTU_BLT;
						rv_isa_pkg::F3_BGE: op = decode_pkg::BTU_BGE;
						rv_isa_pkg::F3_BLTU: op = decode_pkg::BTU_BLTU;
						rv_isa_pkg::F3_BGEU: op = decode_pkg::BTU_BGEU;
						default: illegal = 1'b1;
					endcase
					if (!illegal) begin
						fu = decode_pkg::FU_BTU;
						src1 = rs1;
						src2 = rs2;
						rs1_valid = 1'b1;
						rs2_valid = 1'b1;
						imm = imm_b;
						imm_valid = 1'b1;
						pc_valid = 1'b1;
					end
				end
				rv_isa_pkg::OP_LOAD: begin
					case (funct3)
						rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LH, rv_isa_pkg::F3_LW:
							op = decode_pkg::LS_LOAD;
						rv_isa_pkg::F3_LBU, rv_isa_pkg::F3_LHU:
							op = decode_pkg::LS_LOADU;
						default: illegal = 1'b1;
					endcase
					// loads read rs1 only
					if (!illegal) begin
						fu = decode_pkg::FU_LSU;
						src1 = rs1;
						rs1_valid = 1'b1;
						dest = rd;
						imm = imm_i;
						imm_valid = 1'b1;
						func3 = funct3;
					end
				end
				rv_isa_pkg::OP_STORE: begin
					case (funct3)
						rv_isa_pkg::F3_SB, rv_isa_pkg::F3_SH, rv_isa_pkg::F3_SW:
							op = decode_pkg::LS_STORE;
						default: illegal = 1'b1;
					endcase
					if (!illegal) begin
						fu = decode_pkg::FU_LSU;
						src1 = rs1;
						src2 = rs2;
						rs1_valid = 1'b1;
						rs2_valid = 1'b1;
						imm = imm_s;
						imm_valid = 1'b1;
						func3 = funct3;
					end
				end
				rv_isa_pkg::OP_IMM: begin
					// shifts constrain the upper bits of the immediate
					if ((funct3 == rv_isa_pkg::F3_SLL && funct7 != rv_isa_pkg::FUNCT7_BASE) ||
					    (funct3 == rv_isa_pkg::F3_SR && funct7 != rv_isa_pkg::FUNCT7_BASE &&
					     funct7 != rv_isa_pkg::FUNCT7_ALT)) begin
						illegal = 1'b1;
					end else begin
						op = alu_op(funct3, funct3 == rv_isa_pkg::F3_SR &&
							funct7 == rv_isa_pkg::FUNCT7_ALT);
						src1 = rs1;
						rs1_valid = 1'b1;
						dest = rd;
						imm = imm_i;
						imm_valid = 1'b1;
					end
				end
				rv_isa_pkg::OP_REG: begin
					if (funct7 == rv_isa_pkg::FUNCT7_MULDIV) begin
						// divides have no unit here
						case (funct3)
							rv_isa_pkg::F3_MUL: op = decode_pkg::MULT_MUL;
							rv_isa_pkg::F3_MULH: op = decode_pkg::MULT_MULH;
							rv_isa_pkg::F3_MULHSU: op = decode_pkg::MULT_MULHSU;
							rv_isa_pkg::F3_MULHU: op = decode_pkg::MULT_MULHU;
							default: illegal = 1'b1;
						endcase
					end else if (funct7 == rv_isa_pkg::FUNCT7_BASE ||
					             (funct7 == rv_isa_pkg::FUNCT7_ALT &&
					              (funct3 == rv_isa_pkg::F3_ADD || funct3 == rv_isa_pkg::F3_SR))) begin
						op = alu_op(funct3, funct7 == rv_isa_pkg::FUNCT7_ALT);
					end else begin
						illegal = 1'b1;
					end
					if (!illegal) begin
						fu = (funct7 == rv_isa_pkg::FUNCT7_MULDIV) ?
							decode_pkg::FU_MULT : decode_pkg::FU_ALU;
						src1 = rs1;
						src2 = rs2;
						dest = rd;
						rs1_valid = 1'b1;
						rs2_valid = 1'b1;
					end
				end
				rv_isa_pkg::OP_SYSTEM: begin
					if (inst == rv_isa_pkg::INST_WFI) begin
						halt = 1'b1;
					end else begin
						case (funct3)
							rv_isa_pkg::F3_CSRRW, rv_isa_pkg::F3_CSRRS, rv_isa_pkg::F3_CSRRC:
								csr_op = 1'b1;
							default: illegal = 1'b1;
						endcase
					end
				end
				default: illegal = 1'b1;
			endcase
		end
	end

endmodule

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

	localparam int XLEN = 32;

	typedef logic [31:0] inst_t;
	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// bit positions of the fixed instruction fields
	localparam int OPCODE_LSB = 0;
	localparam int RD_LSB = 7;
	localparam int FUNCT3_LSB = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int FUNCT7_LSB = 25;

	// major opcodes
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_JALR = 3'b000;

	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB = 3'b000;
	localparam logic [2:0] F3_LH = 3'b001;
	localparam logic [2:0] F3_LW = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;

	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	// arithmetic ops, shared by the immediate and register forms
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [2:0] F3_MUL = 3'b000;
	localparam logic [2:0] F3_MULH = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU = 3'b011;

	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [2:0] F3_CSRRC = 3'b011;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	localparam inst_t INST_WFI = 32'h10500073;

endpackage

// ==== project.f ====
logic/rv_isa_pkg.sv
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/fetch_receiver.sv
logic/decode_queue.sv
logic/decode_stage.sv
dv/decode_stage_tb.sv
